/* Bender.yml */
package:
  name: ram_controller

export_include_dirs:
  - src

sources:
  - include_dirs:
      - src
    files:
      - src/ram_ctrl_pkg.sv
      - src/sdram_port_fsm.sv
      - src/main_mem_store.sv
      - src/vram_ports.sv
      - src/ram_controller.sv
  - target: test
    include_dirs:
      - src
    files:
      - verification/tb_ram_controller.sv

/* src/main_mem_store.sv */
// Reads return after MAIN_READ_LATENCY cycles; cmd_full stays high for 2**MAIN_ADDR_BITS clear cycles
`timescale 1ns/10ps
`include "ram_ctrl_consts.svh"

module main_mem_store
   import ram_ctrl_pkg::*;
(
   input logic clk,
   input logic reset,
   input mem_cmd_t cmd,
   input logic cmd_valid,
   output logic cmd_full,
   output mem_rsp_t rsp
);

   localparam int DEPTH = `MAIN_CMD_DEPTH;
   localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_BITS = $clog2(DEPTH + 1);
   localparam int LAT = `MAIN_READ_LATENCY;
   localparam int WORDS = 1 << `MAIN_ADDR_BITS;

   logic [`WORD_BITS-1:0] mem [WORDS];

   mem_cmd_t q [DEPTH];
   logic [PTR_BITS-1:0] wr_ptr;
   logic [PTR_BITS-1:0] rd_ptr;
   logic [CNT_BITS-1:0] count;
   mem_cmd_t head;
   logic head_in_range;
   logic push;
   logic pop;

   logic clearing;
   logic [`MAIN_ADDR_BITS-1:0] clr_addr;

   logic [LAT-1:0] pipe_valid;
   logic [`WORD_BITS-1:0] pipe_data [LAT];

   ////////////////////////////////////////
   // Command queue

   assign cmd_full = clearing || (count == CNT_BITS'(DEPTH));
   assign push = cmd_valid && !cmd_full;
   assign pop = (count != '0) && !clearing;
   assign head = q[rd_ptr];
   assign head_in_range = (head.addr[`SDRAM_ADDR_BITS-1:`MAIN_ADDR_BITS] == '0);

   always_ff @(posedge clk)
   begin
      if (push)
         q[wr_ptr] <= cmd;
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count <= '0;
      end
      else
      begin
         if (push)
            wr_ptr <= (wr_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         if (pop)
            rd_ptr <= (rd_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         count <= count + CNT_BITS'(push) - CNT_BITS'(pop);
      end
   end

   // Zero fill after reset
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         clearing <= 1'b1;
         clr_addr <= '0;
      end
      else if (clearing)
      begin
         clr_addr <= clr_addr + 1'b1;
         if (&clr_addr)
            clearing <= 1'b0;
      end
   end

   ////////////////////////////////////////
   // Word array and read pipe

   always_ff @(posedge clk)
   begin
      if (clearing)
         mem[clr_addr] <= '0;
      else if (pop && head.write && head_in_range)
         mem[head.addr[`MAIN_ADDR_BITS-1:0]] <= head.wdata;
      pipe_data[0] <= head_in_range ? mem[head.addr[`MAIN_ADDR_BITS-1:0]] : '1;
      for (int i = 1; i < LAT; i++)
         pipe_data[i] <= pipe_data[i-1];
   end

   always_ff @(posedge clk)
   begin
      if (reset)
         pipe_valid <= '0;
      else
         pipe_valid <= {pipe_valid[LAT-2:0], pop && !head.write};
   end

   assign rsp = '{valid: pipe_valid[LAT-1], rdata: pipe_data[LAT-1]};

   // Queue never holds more than its depth
   assert property (@(posedge clk) disable iff (reset) count <= CNT_BITS'(DEPTH));

endmodule

/* src/ram_controller.sv */
// Single clock for all clients; main memory reads take 7 cycles and writes 4 without back-pressure
`timescale 1ns/10ps
`include "ram_ctrl_consts.svh"

module ram_controller
   import ram_ctrl_pkg::*;
(
   input logic clk,
   input logic reset,
   input sdram_bus_t sdram,
   output logic [`WORD_BITS-1:0] sdram_rdata,
   output logic sdram_ready,
   output logic sdram_done,
   input vram_cpu_bus_t vram_cpu,
   output logic [`WORD_BITS-1:0] vram_cpu_rdata,
   output logic vram_cpu_ready,
   input logic [`VRAM_ADDR_BITS-1:0] vga_addr,
   input logic vga_req,
   output logic [`WORD_BITS-1:0] vga_rdata,
   output logic vga_ready,
   output port_state_e state_out
);

   mem_cmd_t cmd;
   logic cmd_valid;
   logic cmd_full;
   mem_rsp_t rsp;

   ////////////////////////////////////////
   // Main memory

   sdram_port_fsm u_port (
      .clk(clk),
      .reset(reset),
      .bus(sdram),
      .cmd(cmd),
      .cmd_valid(cmd_valid),
      .cmd_full(cmd_full),
      .rsp(rsp),
      .rdata(sdram_rdata),
      .ready(sdram_ready),
      .done(sdram_done),
      .state(state_out)
   );

   main_mem_store u_store (
      .clk(clk),
      .reset(reset),
      .cmd(cmd),
      .cmd_valid(cmd_valid),
      .cmd_full(cmd_full),
      .rsp(rsp)
   );

   ////////////////////////////////////////
   // Video memory

   vram_ports u_vram (
      .clk(clk),
      .reset(reset),
      .cpu(vram_cpu),
      .cpu_rdata(vram_cpu_rdata),
      .cpu_ready(vram_cpu_ready),
      .vga_addr(vga_addr),
      .vga_req(vga_req),
      .vga_rdata(vga_rdata),
      .vga_ready(vga_ready)
   );

endmodule

/* src/ram_ctrl_consts.svh */
// Word addressed throughout; store depth is 2**MAIN_ADDR_BITS and VRAM above VRAM_WORDS is absent
`ifndef RAM_CTRL_CONSTS_SVH
`define RAM_CTRL_CONSTS_SVH

// Data path
`define WORD_BITS 32

// Processor main-memory port and backing store
`define SDRAM_ADDR_BITS 22
`define MAIN_ADDR_BITS 17
`define MAIN_READ_LATENCY 3
`define MAIN_CMD_DEPTH 2

// Video memory
`define VRAM_ADDR_BITS 15
`define VRAM_WORDS 21504
`define VRAM_CPU_DELAY 4

`endif

/* src/ram_ctrl_pkg.sv */
// Shared bus and store types; field widths follow ram_ctrl_consts.svh
`include "ram_ctrl_consts.svh"

package ram_ctrl_pkg;

   // Processor main-memory request, held steady until ready or done
   typedef struct packed {
      logic [`SDRAM_ADDR_BITS-1:0] addr;
      logic [`WORD_BITS-1:0] wdata;
      logic req;
      logic write;
   } sdram_bus_t;

   // Processor video request
   typedef struct packed {
      logic [`VRAM_ADDR_BITS-1:0] addr;
      logic [`WORD_BITS-1:0] wdata;
      logic req;
      logic write;
   } vram_cpu_bus_t;

   // Store command, full address kept for range decode
   typedef struct packed {
      logic write;
      logic [`SDRAM_ADDR_BITS-1:0] addr;
      logic [`WORD_BITS-1:0] wdata;
   } mem_cmd_t;

   typedef struct packed {
      logic valid;
      logic [`WORD_BITS-1:0] rdata;
   } mem_rsp_t;

   typedef enum logic [3:0] {
      st_idle = 4'd0,
      st_read = 4'd1,
      st_read_busy = 4'd2,
      st_read_wait = 4'd3,
      st_write = 4'd4,
      st_write_busy = 4'd5,
      st_write_wait = 4'd6
   } port_state_e;

endpackage

/* src/sdram_port_fsm.sv */
// Client must never raise req and write together and must hold its inputs until ready or done
`timescale 1ns/10ps
`include "ram_ctrl_consts.svh"

module sdram_port_fsm
   import ram_ctrl_pkg::*;
(
   input logic clk,
   input logic reset,
   input sdram_bus_t bus,
   output mem_cmd_t cmd,
   output logic cmd_valid,
   input logic cmd_full,
   input mem_rsp_t rsp,
   output logic [`WORD_BITS-1:0] rdata,
   output logic ready,
   output logic done,
   output port_state_e state
);

   port_state_e state_next;
   logic cmd_take;
   logic rd_wait;
   logic wr_wait;

   ////////////////////////////////////////
   // Command side

   assign cmd_valid = (state == st_read) || (state == st_write);
   assign cmd_take = cmd_valid && !cmd_full;

   assign cmd = '{write: (state == st_write), addr: bus.addr, wdata: bus.wdata};

   ////////////////////////////////////////
   // State machine

   always_comb
   begin
      state_next = state;
      case (state)
         st_idle:
         begin
            if (bus.req)
               state_next = st_read;
            else if (bus.write)
               state_next = st_write;
         end
         st_read:
            if (cmd_take)
               state_next = st_read_busy;
         st_read_busy:
            if (rsp.valid)
               state_next = st_read_wait;
         st_read_wait:
            if (!bus.req)
               state_next = st_idle;
         // Write data travels with the command
         st_write:
            if (cmd_take)
               state_next = st_write_busy;
         st_write_busy:
            state_next = st_write_wait;
         st_write_wait:
            if (!bus.write)
               state_next = st_idle;
         default:
            state_next = st_idle;
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (reset)
         state <= st_idle;
      else
         state <= state_next;
   end

   ////////////////////////////////////////
   // Client answers

   assign rd_wait = (state == st_read_wait);
   assign wr_wait = (state == st_write_wait);

   // Last read word stays until the next response
   always_ff @(posedge clk)
   begin
      if (reset)
         rdata <= '0;
      else if ((state == st_read_busy) && rsp.valid)
         rdata <= rsp.rdata;
   end

   // Dropped request clears the answer on the next edge
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         ready <= 1'b0;
         done <= 1'b0;
      end
      else
      begin
         ready <= rd_wait && bus.req;
         done <= wr_wait && bus.write;
      end
   end

   assert property (@(posedge clk) disable iff (reset) !(bus.req && bus.write));

   // Store answers only the one read in flight
   assert property (@(posedge clk) disable iff (reset) rsp.valid |-> (state == st_read_busy));

endmodule

/* src/vram_ports.sv */
// Processor writes land in the request cycle; addresses at or above VRAM_WORDS read zero
`timescale 1ns/10ps
`include "ram_ctrl_consts.svh"

module vram_ports
   import ram_ctrl_pkg::*;
(
   input logic clk,
   input logic reset,
   input vram_cpu_bus_t cpu,
   output logic [`WORD_BITS-1:0] cpu_rdata,
   output logic cpu_ready,
   input logic [`VRAM_ADDR_BITS-1:0] vga_addr,
   input logic vga_req,
   output logic [`WORD_BITS-1:0] vga_rdata,
   output logic vga_ready
);

   localparam int DELAY = `VRAM_CPU_DELAY;

   logic [`WORD_BITS-1:0] mem [`VRAM_WORDS];

   logic cpu_in_range;
   logic vga_in_range;
   logic [DELAY-1:0] cpu_ready_dly;
   logic [`WORD_BITS-1:0] vga_q;
   logic [`WORD_BITS-1:0] vga_hold;

   assign cpu_in_range = (cpu.addr < `VRAM_ADDR_BITS'(`VRAM_WORDS));
   assign vga_in_range = (vga_addr < `VRAM_ADDR_BITS'(`VRAM_WORDS));

   ////////////////////////////////////////
   // Processor port

   always_ff @(posedge clk)
   begin
      if (cpu.write && cpu_in_range)
         mem[cpu.addr] <= cpu.wdata;
      if (cpu.req)
         cpu_rdata <= cpu_in_range ? mem[cpu.addr] : '0;
   end

   // Ready trails each req cycle by DELAY clocks
   always_ff @(posedge clk)
   begin
      if (reset)
         cpu_ready_dly <= '0;
      else
         cpu_ready_dly <= {cpu_ready_dly[DELAY-2:0], cpu.req};
   end

   assign cpu_ready = cpu_ready_dly[DELAY-1];

   ////////////////////////////////////////
   // Display port

   always_ff @(posedge clk)
   begin
      if (vga_req)
         vga_q <= vga_in_range ? mem[vga_addr] : '0;
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         vga_ready <= 1'b0;
         vga_hold <= '0;
      end
      else
      begin
         vga_ready <= vga_req;
         if (vga_ready)
            vga_hold <= vga_q;
      end
   end

   // Between fetches the display sees the last word
   assign vga_rdata = vga_ready ? vga_q : vga_hold;

   assert property (@(posedge clk) disable iff (reset) !vga_ready |-> $stable(vga_rdata));

endmodule

/* tb.f */
+incdir+src
src/ram_ctrl_pkg.sv
src/sdram_port_fsm.sv
src/main_mem_store.sv
src/vram_ports.sv
src/ram_controller.sv
verification/tb_ram_controller.sv

/* verification/tb_ram_controller.sv */
// Each reset starts a 2**17 cycle store clear, so the first main-memory access waits for it
`timescale 1ns/10ps
`include "ram_ctrl_consts.svh"

module tb_ram_controller
   import ram_ctrl_pkg::*;
();

   localparam logic [`VRAM_ADDR_BITS-1:0] vram_base = 15'h0100;

   logic clk;
   logic reset;
   sdram_bus_t sdram;
   logic [`WORD_BITS-1:0] sdram_rdata;
   logic sdram_ready;
   logic sdram_done;
   vram_cpu_bus_t vram_cpu;
   logic [`WORD_BITS-1:0] vram_cpu_rdata;
   logic vram_cpu_ready;
   logic [`VRAM_ADDR_BITS-1:0] vga_addr;
   logic vga_req;
   logic [`WORD_BITS-1:0] vga_rdata;
   logic vga_ready;
   port_state_e state_out;

   integer seed = 39;
   int errors = 0;
   int tests = 0;
   int failed_tests = 0;
   int errors_at_start;
   logic [`WORD_BITS-1:0] main_ref [int];
   logic [`WORD_BITS-1:0] vram_ref [int];
   logic [`WORD_BITS-1:0] dummy_data;
   int dummy_cycles;

   ram_controller DUT (.*);

   initial
   begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   ////////////////////////////////////////
   // Helpers

   task automatic step();
      @(posedge clk);
      #2;
   endtask

   task automatic check_value(input string name, input logic [31:0] got,
      input logic [31:0] exp);
      if (got !== exp)
      begin
         $display("Fail %s: got %h expected %h", name, got, exp);
         errors++;
      end
   endtask

   task automatic start_test();
      errors_at_start = errors;
      tests++;
   endtask

   task automatic finish_test(input string name);
      if (errors == errors_at_start)
         $display("Test %0d %s: passed", tests, name);
      else
      begin
         $display("Test %0d %s: %0d errors", tests, name, errors - errors_at_start);
         failed_tests++;
      end
   endtask

   // Unwritten store words are zero after the clear
   function automatic logic [31:0] main_expect(input logic [`MAIN_ADDR_BITS-1:0] addr);
      return main_ref.exists(addr) ? main_ref[addr] : 32'h0;
   endfunction

   function automatic logic [31:0] vram_expect(input logic [`VRAM_ADDR_BITS-1:0] addr);
      if (addr >= `VRAM_WORDS || !vram_ref.exists(addr))
         return 32'h0;
      return vram_ref[addr];
   endfunction

   // One main-memory access, held for extra cycles after the answer
   task automatic main_access(input logic wr, input logic [`SDRAM_ADDR_BITS-1:0] addr,
      input logic [31:0] wdata, input int hold, input int limit,
      output logic [31:0] rdata, output int cycles);
      logic [31:0] held;
      logic answered;
      string hs_name;
      string other_name;
      hs_name = wr ? "sdram_done" : "sdram_ready";
      other_name = wr ? "sdram_ready" : "sdram_done";
      sdram = '{addr: addr, wdata: wdata, req: !wr, write: wr};
      cycles = 0;
      answered = 1'b0;
      while (!answered && cycles < limit)
      begin
         step();
         cycles++;
         answered = wr ? sdram_done : sdram_ready;
         check_value(other_name, wr ? sdram_ready : sdram_done, 1'b0);
      end
      if (!answered)
      begin
         $display("Timeout: %s at address %h got no answer within %0d cycles",
            wr ? "write" : "read", addr, limit);
         errors++;
      end
      held = sdram_rdata;
      for (int h = 0; h < hold; h++)
      begin
         step();
         check_value(hs_name, wr ? sdram_done : sdram_ready, 1'b1);
         check_value(other_name, wr ? sdram_ready : sdram_done, 1'b0);
         check_value("sdram_rdata", sdram_rdata, held);
      end
      sdram.req = 1'b0;
      sdram.write = 1'b0;
      step();
      check_value(hs_name, wr ? sdram_done : sdram_ready, 1'b0);
      check_value("state_out", state_out, st_idle);
      rdata = sdram_rdata;
   endtask

   task automatic main_write(input logic [`SDRAM_ADDR_BITS-1:0] addr, input logic [31:0] data);
      logic [31:0] unused;
      int cycles;
      main_access(1'b1, addr, data, 0, 20, unused, cycles);
      check_value("write latency", cycles, 4);
   endtask

   task automatic main_read(input logic [`SDRAM_ADDR_BITS-1:0] addr, input int hold,
      output logic [31:0] data);
      int cycles;
      main_access(1'b0, addr, 32'h0, hold, 20, data, cycles);
      check_value("read latency", cycles, `MAIN_READ_LATENCY + 4);
   endtask

   task automatic vga_fetch(input logic [`VRAM_ADDR_BITS-1:0] addr);
      vga_addr = addr;
      vga_req = 1'b1;
      step();
      check_value("vga_ready", vga_ready, 1'b1);
      check_value("vga_rdata", vga_rdata, vram_expect(addr));
      vga_req = 1'b0;
      step();
      check_value("vga_ready", vga_ready, 1'b0);
      check_value("vga_rdata", vga_rdata, vram_expect(addr));
   endtask

   ////////////////////////////////////////
   // Directed tests

   task automatic test_main_rw();
      logic [`MAIN_ADDR_BITS-1:0] addrs [20];
      logic [31:0] data;
      logic [31:0] got;
      for (int i = 0; i < 20; i++)
      begin
         addrs[i] = `MAIN_ADDR_BITS'($random(seed));
         // Every fourth address stays unwritten
         if (i % 4 != 3)
         begin
            data = $random(seed);
            main_write({5'd0, addrs[i]}, data);
            main_ref[addrs[i]] = data;
         end
      end
      data = $random(seed);
      main_write({5'd0, addrs[0]}, data);
      main_ref[addrs[0]] = data;
      for (int i = 0; i < 20; i++)
      begin
         main_read({5'd0, addrs[i]}, 0, got);
         check_value("sdram_rdata", got, main_expect(addrs[i]));
      end
   endtask

   task automatic test_out_of_range();
      logic [31:0] got;
      logic [31:0] data;
      data = $random(seed);
      main_write(22'h0_0123, data);
      main_ref[17'h00123] = data;
      main_write(22'h6_0123, ~data);
      main_read(22'h6_0123, 0, got);
      check_value("sdram_rdata", got, 32'hffff_ffff);
      main_read(22'h0_0123, 0, got);
      check_value("sdram_rdata", got, main_expect(17'h00123));
   endtask

   task automatic test_hold();
      logic [31:0] got;
      logic [31:0] data;
      data = $random(seed);
      main_write(22'h0_0abc, data);
      main_ref[17'h00abc] = data;
      main_read(22'h0_0abc, 3, got);
      check_value("sdram_rdata", got, main_expect(17'h00abc));
      repeat (5)
      begin
         step();
         check_value("sdram_rdata", sdram_rdata, main_expect(17'h00abc));
      end
   endtask

   task automatic test_vram_cpu();
      logic [31:0] data;
      logic req_pat [22];
      logic [`VRAM_ADDR_BITS-1:0] far_addr [2];
      for (int i = 0; i < 16; i++)
      begin
         data = $random(seed);
         vram_cpu = '{addr: vram_base + 15'(i), wdata: data, req: 1'b0, write: 1'b1};
         vram_ref[vram_base + 15'(i)] = data;
         step();
      end
      vram_cpu = '0;
      for (int s = 0; s < 22; s++)
         req_pat[s] = (s < 16);
      for (int s = 0; s < 22; s++)
      begin
         vram_cpu.req = req_pat[s];
         vram_cpu.addr = vram_base + 15'(s);
         step();
         if (req_pat[s])
            check_value("vram_cpu_rdata", vram_cpu_rdata, vram_expect(vram_base + 15'(s)));
         // Sample lands after one edge, so four cycles of delay show as three steps
         check_value("vram_cpu_ready", vram_cpu_ready, (s >= 3) ? req_pat[s-3] : 1'b0);
      end
      far_addr[0] = `VRAM_ADDR_BITS'(`VRAM_WORDS);
      far_addr[1] = '1;
      for (int i = 0; i < 2; i++)
      begin
         vram_cpu = '{addr: far_addr[i], wdata: $random(seed), req: 1'b0, write: 1'b1};
         step();
         vram_cpu = '{addr: far_addr[i], wdata: 32'h0, req: 1'b1, write: 1'b0};
         step();
         check_value("vram_cpu_rdata", vram_cpu_rdata, vram_expect(far_addr[i]));
      end
      vram_cpu = '0;
      step();
   endtask

   task automatic test_vga();
      logic [31:0] kept;
      for (int i = 0; i < 4; i++)
         vga_fetch(vram_base + 15'(i * 5));
      kept = vram_expect(vram_base + 15'd15);
      vram_cpu = '{addr: vram_base + 15'd15, wdata: ~kept, req: 1'b0, write: 1'b1};
      vram_ref[vram_base + 15'd15] = ~kept;
      step();
      vram_cpu = '0;
      repeat (3)
      begin
         step();
         check_value("vga_rdata", vga_rdata, kept);
      end
      vga_fetch(vram_base + 15'd15);
   endtask

   task automatic test_reset();
      reset = 1'b1;
      repeat (2) step();
      reset = 1'b0;
      step();
      check_value("sdram_ready", sdram_ready, 1'b0);
      check_value("sdram_done", sdram_done, 1'b0);
      check_value("vram_cpu_ready", vram_cpu_ready, 1'b0);
      check_value("vga_ready", vga_ready, 1'b0);
      check_value("state_out", state_out, st_idle);
      check_value("vga_rdata", vga_rdata, 32'h0);
      check_value("sdram_rdata", sdram_rdata, 32'h0);
   endtask

   ////////////////////////////////////////
   // Sequence

   initial
   begin
      reset = 1'b1;
      sdram = '0;
      vram_cpu = '0;
      vga_addr = '0;
      vga_req = 1'b0;
      repeat (10) @(posedge clk);
      #2;
      reset = 1'b0;
      // Dummy read returns once the store clear is over
      main_access(1'b0, '0, 32'h0, 0, 140000, dummy_data, dummy_cycles);
      check_value("sdram_rdata", dummy_data, 32'h0);
      start_test();
      test_main_rw();
      finish_test("main memory write and read-back");
      start_test();
      test_out_of_range();
      finish_test("main memory out of range");
      start_test();
      test_hold();
      finish_test("handshake hold");
      start_test();
      test_vram_cpu();
      finish_test("video processor port");
      start_test();
      test_vga();
      finish_test("display port");
      start_test();
      test_reset();
      finish_test("reset state");
      $display("Tests: %0d, failed tests: %0d, failed checks: %0d", tests, failed_tests, errors);
      if (errors == 0)
         $display("Everything OK");
      else
         $display("Something failed");
      $finish;
   end

endmodule
